/* project.f */
design/alu_pkg.sv
design/ctrl_pkg.sv
design/dp_ram.sv
design/page_tbl_writer.sv
design/alu_core.sv
design/stateful_alu.sv
tb/stateful_alu_sva.sv
tb/stateful_alu_tb.sv

/* Bender.yml */
package:
  name: stateful_alu

sources:
  - design/alu_pkg.sv
  - design/ctrl_pkg.sv
  - design/dp_ram.sv
  - design/page_tbl_writer.sv
  - design/alu_core.sv
  - design/stateful_alu.sv
  - target: test
    files:
      - tb/stateful_alu_sva.sv
      - tb/stateful_alu_tb.sv

/* tb/stateful_alu_tb.sv */
module stateful_alu_tb;

	import alu_pkg::*;
	import ctrl_pkg::*;

	localparam int TIMEOUT = 40;
	// stage 0, action 3
	localparam mod_id_t OWN_MOD_ID = 8'h03;

	logic clk;
	logic rst_n;
	action_t action_in;
	logic action_valid;
	data_t operand_1_in;
	data_t operand_2_in;
	data_t operand_3_in;
	logic ready_out;
	vlan_t vlan_id;
	data_t container_out;
	logic container_out_valid;
	logic ready_in;
	ctrl_data_t c_s_axis_tdata;
	logic c_s_axis_tvalid;
	logic c_s_axis_tlast;
	ctrl_data_t c_m_axis_tdata;
	logic c_m_axis_tvalid;
	logic c_m_axis_tlast;

	integer seed = 10633;
	opcode_t arith_ops [6] = '{OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_SET, 4'b0011};

	// reference model of memory and page table
	data_t kv_model [KV_DEPTH];
	seg_field_t pt_base [PT_DEPTH];
	seg_field_t pt_len [PT_DEPTH];

	// control input of the last two cycles, older one at index 1
	ctrl_data_t hist_data [2];
	logic [1:0] hist_valid;
	logic [1:0] hist_last;
	logic [1:0] hist_drop;
	logic drop_now;
	int hold;

	stateful_alu stateful_alu_i (.*);

	always #10 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		assert (got === exp)
		else abort_run($sformatf("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp));
	endtask

	function automatic ctrl_data_t random_beat();
		ctrl_data_t beat;
		int i;
		for (i = 0; i < 8; i++) begin
			beat[32*i +: 32] = $random(seed);
		end
		return beat;
	endfunction

	function automatic data_t offset_word(input ram_addr_t off);
		return {27'($random(seed)), off};
	endfunction

	// expected result, memory effects applied to the model
	function automatic data_t model_op(input opcode_t op, input data_t a, input data_t b,
			input data_t c, input tenant_t t);
		ram_addr_t off;
		ram_addr_t addr;
		logic over;
		data_t r;
		off = b[4:0];
		addr = ram_addr_t'(pt_base[t] + off);
		over = off > pt_len[t];
		r = c;
		case (op)
			OP_ADD, OP_ADDI: r = a + b;
			OP_SUB, OP_SUBI: r = a - b;
			OP_SET: r = b;
			OP_STORE: if (!over) kv_model[addr] = a;
			OP_LOAD: if (!over) r = kv_model[addr];
			OP_LOADD: begin
				if (!over) begin
					r = kv_model[addr] + 1;
					kv_model[addr] = r;
				end
			end
			default: r = c;
		endcase
		return r;
	endfunction

	// hold > 0 keeps ready_in low until that cycle after acceptance
	task automatic run_op(input opcode_t op, input data_t a, input data_t b, input data_t c,
			input tenant_t t, input int hold);
		data_t exp;
		int n;
		exp = model_op(op, a, b, c, t);
		n = 0;
		while (!ready_out) begin
			@(posedge clk);
			#2;
			n++;
			if (n > TIMEOUT) abort_run("ready_out stayed low before a new action");
		end
		action_in = {op, 21'($random(seed))};
		operand_1_in = a;
		operand_2_in = b;
		operand_3_in = c;
		vlan_id = {3'($random(seed)), t, 4'($random(seed))};
		ready_in = (hold == 0);
		action_valid = 1'b1;
		@(posedge clk);
		#2;
		action_valid = 1'b0;
		n = 1;
		while (!container_out_valid) begin
			if (n == hold) ready_in = 1'b1;
			@(posedge clk);
			#2;
			n++;
			if (n > TIMEOUT + hold) abort_run("no container_out_valid pulse after an action");
		end
		check_value("container_out_valid cycle", n, (hold == 0) ? 5 : hold + 1);
		check_value("container_out", container_out, exp);
		@(posedge clk);
		#2;
		check_value("container_out_valid", container_out_valid, 1'b0);
	endtask

	task automatic send_packet(input ctrl_data_t b1, input ctrl_data_t b2, input logic drop);
		ctrl_data_t beats [3];
		int i;
		beats[0] = random_beat();
		beats[1] = b1;
		beats[2] = b2;
		drop_now = drop;
		for (i = 0; i < 3; i++) begin
			c_s_axis_tdata = beats[i];
			c_s_axis_tvalid = 1'b1;
			c_s_axis_tlast = (i == 2);
			@(posedge clk);
			#2;
		end
		c_s_axis_tvalid = 1'b0;
		c_s_axis_tlast = 1'b0;
		drop_now = 1'b0;
	endtask

	task automatic configure_tenant(input tenant_t t, input seg_field_t base,
			input seg_field_t len);
		ctrl_data_t b1;
		ctrl_data_t b2;
		b1 = random_beat();
		b1[MOD_ID_LSB +: 8] = OWN_MOD_ID;
		b1[FLAG_LSB +: 16] = CTRL_FLAG;
		b1[INDEX_LSB +: 8] = {3'($random(seed)), t};
		b2 = random_beat();
		// byte 0 length, byte 1 base
		b2[15:0] = {base, len};
		send_packet(b1, b2, 1'b1);
		pt_base[t] = base;
		pt_len[t] = len;
	endtask

	// forwarded beats show up two cycles later unless dropped
	always @(negedge clk) begin
		if (rst_n) begin
			check_value("c_m_axis_tvalid", c_m_axis_tvalid, hist_valid[1] & ~hist_drop[1]);
			if (hist_valid[1] && !hist_drop[1]) begin
				check_value("c_m_axis_tdata", c_m_axis_tdata, hist_data[1]);
				check_value("c_m_axis_tlast", c_m_axis_tlast, hist_last[1]);
			end
		end
		hist_data[1] = hist_data[0];
		hist_data[0] = c_s_axis_tdata;
		hist_valid = {hist_valid[0], c_s_axis_tvalid};
		hist_last = {hist_last[0], c_s_axis_tlast};
		hist_drop = {hist_drop[0], drop_now};
	end

	initial begin
		@(posedge stateful_alu_i.stateful_alu_sva_i.failed);
		abort_run("a protocol assertion on the ALU ports failed");
	end

	initial begin
		ctrl_data_t b1;
		clk = 1'b0;
		rst_n = 1'b1;
		action_in = '0;
		action_valid = 1'b0;
		operand_1_in = '0;
		operand_2_in = '0;
		operand_3_in = '0;
		vlan_id = '0;
		ready_in = 1'b1;
		c_s_axis_tdata = '0;
		c_s_axis_tvalid = 1'b0;
		c_s_axis_tlast = 1'b0;
		drop_now = 1'b0;
		hist_valid = '0;
		hist_last = '0;
		hist_drop = '0;
		#1 rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_value("ready_out", ready_out, 1'b1);
		check_value("container_out_valid", container_out_valid, 1'b0);
		check_value("c_m_axis_tvalid", c_m_axis_tvalid, 1'b0);

		// foreign stage id, passes through
		b1 = random_beat();
		b1[MOD_ID_LSB +: 8] = OWN_MOD_ID ^ 8'h08;
		b1[FLAG_LSB +: 16] = CTRL_FLAG;
		send_packet(b1, random_beat(), 1'b0);
		configure_tenant(5'd1, 8'd0, 8'd7);
		configure_tenant(5'd2, 8'd16, 8'd7);
		// tenant 3 covers addresses 8 to 15
		configure_tenant(5'd3, 8'd8, 8'd7);
		repeat (3) @(posedge clk);
		#2;

		foreach (arith_ops[i]) begin
			run_op(arith_ops[i], $random(seed), $random(seed), $random(seed), 5'd1, 0);
		end

		// same local offset in both tenants
		run_op(OP_STORE, $random(seed), offset_word(5'd3), $random(seed), 5'd1, 0);
		run_op(OP_STORE, $random(seed), offset_word(5'd3), $random(seed), 5'd2, 0);
		run_op(OP_LOAD, $random(seed), offset_word(5'd3), $random(seed), 5'd1, 0);
		run_op(OP_LOAD, $random(seed), offset_word(5'd3), $random(seed), 5'd2, 0);
		run_op(OP_LOADD, $random(seed), offset_word(5'd3), $random(seed), 5'd1, 0);
		run_op(OP_LOAD, $random(seed), offset_word(5'd3), $random(seed), 5'd1, 0);
		run_op(OP_LOADD, $random(seed), offset_word(5'd3), $random(seed), 5'd2, 0);
		run_op(OP_LOAD, $random(seed), offset_word(5'd3), $random(seed), 5'd2, 0);

		// offset 9 is past length 7
		// address 9 is offset 1 of tenant 3
		run_op(OP_STORE, $random(seed), offset_word(5'd1), $random(seed), 5'd3, 0);
		run_op(OP_STORE, $random(seed), offset_word(5'd9), $random(seed), 5'd1, 0);
		run_op(OP_LOAD, $random(seed), offset_word(5'd9), $random(seed), 5'd1, 0);
		run_op(OP_LOAD, $random(seed), offset_word(5'd1), $random(seed), 5'd3, 0);

		hold = 5 + ($unsigned($random(seed)) % 8);
		run_op(OP_SUB, $random(seed), $random(seed), $random(seed), 5'd1, hold);
		hold = 5 + ($unsigned($random(seed)) % 8);
		run_op(OP_LOADD, $random(seed), offset_word(5'd3), $random(seed), 5'd2, hold);
		run_op(OP_LOAD, $random(seed), offset_word(5'd3), $random(seed), 5'd2, 0);

		if (stateful_alu_i.stateful_alu_sva_i.failed) begin
			abort_run("a protocol assertion on the ALU ports failed");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

/* tb/stateful_alu_sva.sv */
module stateful_alu_sva (
	input logic clk,
	input logic rst_n,
	input logic action_valid,
	input logic ready_out,
	input logic ready_in,
	input logic container_out_valid,
	input logic c_m_axis_tvalid
);

	logic failed;
	logic accept;

	initial failed = 1'b0;

	assign accept = action_valid && ready_out;

	reset_values: assert property (@(posedge clk)
		!rst_n |-> ready_out && !container_out_valid && !c_m_axis_tvalid)
	else begin
		$error("outputs differ from their reset values while rst_n is low");
		failed = 1'b1;
	end

	// LOOKUP, BOUND, READ, OUTPUT, then the pulse
	result_latency: assert property (@(posedge clk) disable iff (!rst_n)
		accept ##4 ready_in |=> container_out_valid)
	else begin
		$error("no result pulse five cycles after an accepted action");
		failed = 1'b1;
	end

	valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		container_out_valid |=> !container_out_valid)
	else begin
		$error("container_out_valid lasted longer than one cycle");
		failed = 1'b1;
	end

	valid_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
		container_out_valid |-> $rose(ready_out))
	else begin
		$error("result pulse without ready_out rising");
		failed = 1'b1;
	end

	// low from acceptance, back up only with the result
	busy_on_accept: assert property (@(posedge clk) disable iff (!rst_n)
		accept |=> !ready_out)
	else begin
		$error("ready_out still high after an accepted action");
		failed = 1'b1;
	end

	ready_with_result: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ready_out) |-> container_out_valid)
	else begin
		$error("ready_out rose while an action was pending");
		failed = 1'b1;
	end

endmodule

bind stateful_alu stateful_alu_sva stateful_alu_sva_i (.*);

/* design/stateful_alu.sv */
module stateful_alu #(
	parameter int STAGE_ID = 0,
	parameter int ACTION_ID = 3
) (
	input  logic                 clk,
	input  logic                 rst_n,

	input  alu_pkg::action_t     action_in,
	input  logic                 action_valid,
	input  alu_pkg::data_t       operand_1_in,
	input  alu_pkg::data_t       operand_2_in,
	input  alu_pkg::data_t       operand_3_in,
	output logic                 ready_out,

	input  alu_pkg::vlan_t       vlan_id,

	output alu_pkg::data_t       container_out,
	output logic                 container_out_valid,
	input  logic                 ready_in,

	input  ctrl_pkg::ctrl_data_t c_s_axis_tdata,
	input  logic                 c_s_axis_tvalid,
	input  logic                 c_s_axis_tlast,

	output ctrl_pkg::ctrl_data_t c_m_axis_tdata,
	output logic                 c_m_axis_tvalid,
	output logic                 c_m_axis_tlast
);

	import alu_pkg::*;
	import ctrl_pkg::*;

	logic pt_wr_en;
	tenant_t pt_wr_index;
	page_entry_t pt_wr_entry;
	page_entry_t page_entry;

	ram_addr_t kv_rd_addr;
	data_t kv_rd_data;
	logic kv_wr_en;
	ram_addr_t kv_wr_addr;
	data_t kv_wr_data;

	page_tbl_writer #(
		.STAGE_ID (STAGE_ID),
		.ACTION_ID(ACTION_ID)
	) page_tbl_writer_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.c_s_axis_tdata (c_s_axis_tdata),
		.c_s_axis_tvalid(c_s_axis_tvalid),
		.c_s_axis_tlast (c_s_axis_tlast),
		.c_m_axis_tdata (c_m_axis_tdata),
		.c_m_axis_tvalid(c_m_axis_tvalid),
		.c_m_axis_tlast (c_m_axis_tlast),
		.pt_wr_en       (pt_wr_en),
		.pt_wr_index    (pt_wr_index),
		.pt_wr_entry    (pt_wr_entry)
	);

	// tenant field of the vlan id picks the entry
	dp_ram #(
		.WIDTH($bits(page_entry_t)),
		.DEPTH(PT_DEPTH)
	) page_tbl (
		.clk    (clk),
		.wr_en  (pt_wr_en),
		.wr_addr(pt_wr_index),
		.wr_data(pt_wr_entry),
		.rd_addr(vlan_id[TENANT_LSB +: TENANT_W]),
		.rd_data(page_entry)
	);

	dp_ram #(
		.WIDTH($bits(data_t)),
		.DEPTH(KV_DEPTH)
	) kv_mem (
		.clk    (clk),
		.wr_en  (kv_wr_en),
		.wr_addr(kv_wr_addr),
		.wr_data(kv_wr_data),
		.rd_addr(kv_rd_addr),
		.rd_data(kv_rd_data)
	);

	alu_core alu_core_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.action_in          (action_in),
		.action_valid       (action_valid),
		.operand_1_in       (operand_1_in),
		.operand_2_in       (operand_2_in),
		.operand_3_in       (operand_3_in),
		.ready_out          (ready_out),
		.container_out      (container_out),
		.container_out_valid(container_out_valid),
		.ready_in           (ready_in),
		.page_entry         (page_entry),
		.kv_rd_addr         (kv_rd_addr),
		.kv_rd_data         (kv_rd_data),
		.kv_wr_en           (kv_wr_en),
		.kv_wr_addr         (kv_wr_addr),
		.kv_wr_data         (kv_wr_data)
	);

endmodule

/* design/alu_core.sv */
module alu_core (
	input  logic                 clk,
	input  logic                 rst_n,

	input  alu_pkg::action_t     action_in,
	input  logic                 action_valid,
	input  alu_pkg::data_t       operand_1_in,
	input  alu_pkg::data_t       operand_2_in,
	input  alu_pkg::data_t       operand_3_in,
	output logic                 ready_out,

	output alu_pkg::data_t       container_out,
	output logic                 container_out_valid,
	input  logic                 ready_in,

	input  alu_pkg::page_entry_t page_entry,

	output alu_pkg::ram_addr_t   kv_rd_addr,
	input  alu_pkg::data_t       kv_rd_data,
	output logic                 kv_wr_en,
	output alu_pkg::ram_addr_t   kv_wr_addr,
	output alu_pkg::data_t       kv_wr_data
);

	import alu_pkg::*;

	alu_state_e state;

	opcode_t opcode;
	opcode_t opcode_in;
	ram_addr_t offset;
	ram_addr_t ram_addr;
	logic overflow;
	logic over_now;
	logic accept;
	logic done;

	data_t arith;
	data_t load_inc;
	seg_field_t seg_len;
	seg_field_t seg_base;

	assign opcode_in = action_in[OPCODE_LSB +: OPCODE_W];
	assign accept = action_valid & ready_out;
	assign {seg_len, seg_base} = page_entry;

	// local offset past the tenant's length
	assign over_now = seg_field_t'(offset) > seg_len;

	assign load_inc = kv_rd_data + data_t'(1);
	assign done = ((state == OUTPUT) || (state == HALT)) && ready_in;

	// one address register serves both ports
	assign kv_rd_addr = ram_addr;
	assign kv_wr_addr = ram_addr;

	// result known at acceptance, loads replace it later
	always_comb begin
		case (opcode_in)
			OP_ADD, OP_ADDI: arith = operand_1_in + operand_2_in;
			OP_SUB, OP_SUBI: arith = operand_1_in - operand_2_in;
			OP_SET: arith = operand_2_in;
			default: arith = operand_3_in;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			opcode <= '0;
			overflow <= 1'b0;
			ready_out <= 1'b1;
			container_out_valid <= 1'b0;
			kv_wr_en <= 1'b0;
		end else begin
			container_out_valid <= 1'b0;
			kv_wr_en <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						opcode <= opcode_in;
						ready_out <= 1'b0;
						state <= LOOKUP;
					end
				end
				// page table read in flight
				LOOKUP: state <= BOUND;
				BOUND: begin
					overflow <= over_now;
					if ((opcode == OP_STORE) && !over_now) begin
						kv_wr_en <= 1'b1;
					end
					state <= READ;
				end
				READ: state <= OUTPUT;
				OUTPUT: begin
					// write back of loadd goes out once
					if ((opcode == OP_LOADD) && !overflow) begin
						kv_wr_en <= 1'b1;
					end
					state <= ready_in ? IDLE : HALT;
				end
				HALT: begin
					if (ready_in) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
			if (done) begin
				container_out_valid <= 1'b1;
				ready_out <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state == IDLE) && accept) begin
			container_out <= arith;
			offset <= operand_2_in[RAM_ADDR_W-1:0];
		end
		if (state == BOUND) begin
			ram_addr <= ram_addr_t'(seg_base) + offset;
			kv_wr_data <= operand_1_in;
		end
		// overflowed loads keep operand 3
		if ((state == OUTPUT) && !overflow) begin
			if (opcode == OP_LOAD) begin
				container_out <= kv_rd_data;
			end else if (opcode == OP_LOADD) begin
				container_out <= load_inc;
				kv_wr_data <= load_inc;
			end
		end
	end

endmodule

/* design/page_tbl_writer.sv */
module page_tbl_writer #(
	parameter int STAGE_ID = 0,
	parameter int ACTION_ID = 3
) (
	input  logic                 clk,
	input  logic                 rst_n,

	input  ctrl_pkg::ctrl_data_t c_s_axis_tdata,
	input  logic                 c_s_axis_tvalid,
	input  logic                 c_s_axis_tlast,

	output ctrl_pkg::ctrl_data_t c_m_axis_tdata,
	output logic                 c_m_axis_tvalid,
	output logic                 c_m_axis_tlast,

	output logic                 pt_wr_en,
	output alu_pkg::tenant_t     pt_wr_index,
	output alu_pkg::page_entry_t pt_wr_entry
);

	import alu_pkg::*;
	import ctrl_pkg::*;

	localparam mod_id_t OWN_MOD_ID =
		mod_id_t'({STAGE_ID[MOD_STAGE_W-1:0], ACTION_ID[MOD_ACTION_W-1:0]});

	ctrl_state_e state;

	// two-stage beat delay line
	ctrl_data_t d1_data;
	ctrl_data_t d2_data;
	logic d1_valid;
	logic d2_valid;
	logic d1_last;
	logic d2_last;
	logic d1_drop;
	logic d2_drop;

	logic pkt_drop;
	logic in_drop;
	logic match;

	mod_id_t mod_id;
	ctrl_flag_t ctrl_flag;
	seg_field_t beat_len;
	seg_field_t beat_base;

	assign mod_id = c_s_axis_tdata[MOD_ID_LSB +: $bits(mod_id_t)];
	assign ctrl_flag = c_s_axis_tdata[FLAG_LSB +: $bits(ctrl_flag_t)];
	assign match = c_s_axis_tvalid && (mod_id == OWN_MOD_ID) && (ctrl_flag == CTRL_FLAG);

	// entry bytes arrive little endian
	assign beat_len = c_s_axis_tdata[0 +: SEG_W];
	assign beat_base = c_s_axis_tdata[SEG_W +: SEG_W];

	// drop flag for the beat entering now
	always_comb begin
		case (state)
			CHECK: in_drop = match;
			ENTRY, REST: in_drop = pkt_drop;
			default: in_drop = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d1_valid <= 1'b0;
			d1_last <= 1'b0;
			d1_drop <= 1'b0;
			d2_valid <= 1'b0;
			d2_last <= 1'b0;
			d2_drop <= 1'b0;
		end else begin
			d1_valid <= c_s_axis_tvalid;
			d1_last <= c_s_axis_tlast;
			d1_drop <= in_drop;
			d2_valid <= d1_valid;
			d2_last <= d1_last;
			// first beat sits in d1 while the second one is checked
			d2_drop <= d1_drop | ((state == CHECK) && match);
		end
	end

	always_ff @(posedge clk) begin
		d1_data <= c_s_axis_tdata;
		d2_data <= d1_data;
	end

	assign c_m_axis_tdata = d2_data;
	assign c_m_axis_tvalid = d2_valid & ~d2_drop;
	assign c_m_axis_tlast = d2_last & ~d2_drop;

	// packet parser
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FIRST;
			pkt_drop <= 1'b0;
			pt_wr_en <= 1'b0;
		end else begin
			pt_wr_en <= 1'b0;
			case (state)
				FIRST: begin
					if (c_s_axis_tvalid && !c_s_axis_tlast) begin
						state <= CHECK;
					end
				end
				CHECK: begin
					if (c_s_axis_tvalid) begin
						pkt_drop <= match;
						if (c_s_axis_tlast) begin
							state <= FIRST;
						end else if (match) begin
							state <= ENTRY;
						end else begin
							state <= REST;
						end
					end
				end
				ENTRY: begin
					if (c_s_axis_tvalid) begin
						pt_wr_en <= 1'b1;
						state <= c_s_axis_tlast ? FIRST : REST;
					end
				end
				REST: begin
					if (c_s_axis_tvalid && c_s_axis_tlast) begin
						state <= FIRST;
					end
				end
				default: state <= FIRST;
			endcase
		end
	end

	// index from beat two, entry from beat three
	always_ff @(posedge clk) begin
		if ((state == CHECK) && match) begin
			pt_wr_index <= c_s_axis_tdata[INDEX_LSB +: TENANT_W];
		end
		if ((state == ENTRY) && c_s_axis_tvalid) begin
			pt_wr_entry <= {beat_len, beat_base};
		end
	end

endmodule

/* design/dp_ram.sv */
module dp_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 32
) (
	input  logic                     clk,
	input  logic                     wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  logic [WIDTH-1:0]         wr_data,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output logic [WIDTH-1:0]         rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	// read-before-write on an address collision
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

/* design/ctrl_pkg.sv */
package ctrl_pkg;

	localparam int CTRL_W = 256;

	typedef logic [CTRL_W-1:0] ctrl_data_t;
	typedef logic [7:0] mod_id_t;
	typedef logic [15:0] ctrl_flag_t;

	// mod id splits into stage (upper) and action (lower)
	localparam int MOD_STAGE_W = 5;
	localparam int MOD_ACTION_W = 3;

	// field positions inside the second beat
	localparam int MOD_ID_LSB = 112;
	localparam int FLAG_LSB = 64;
	localparam int INDEX_LSB = 128;

	// udp port marking a configuration packet
	localparam ctrl_flag_t CTRL_FLAG = 16'hf2f1;

	typedef enum logic [1:0] {FIRST, CHECK, ENTRY, REST} ctrl_state_e;

endpackage

/* design/alu_pkg.sv */
package alu_pkg;

	// datapath widths
	localparam int DATA_W = 32;
	localparam int ACTION_W = 25;
	localparam int OPCODE_W = 4;
	localparam int OPCODE_LSB = 21;

	// tenant isolation
	localparam int VLAN_W = 12;
	localparam int TENANT_W = 5;
	localparam int TENANT_LSB = 4;
	localparam int RAM_ADDR_W = 5;
	localparam int SEG_W = 8;

	localparam int KV_DEPTH = 32;
	localparam int PT_DEPTH = 32;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ACTION_W-1:0] action_t;
	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [VLAN_W-1:0] vlan_t;
	typedef logic [TENANT_W-1:0] tenant_t;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [SEG_W-1:0] seg_field_t;
	// length in the upper byte, base in the lower byte
	typedef logic [2*SEG_W-1:0] page_entry_t;

	localparam opcode_t OP_ADD = 4'b0001;
	localparam opcode_t OP_SUB = 4'b0010;
	localparam opcode_t OP_ADDI = 4'b1001;
	localparam opcode_t OP_SUBI = 4'b1010;
	localparam opcode_t OP_STORE = 4'b1000;
	localparam opcode_t OP_LOAD = 4'b1011;
	localparam opcode_t OP_LOADD = 4'b0111;
	localparam opcode_t OP_SET = 4'b1110;

	typedef enum logic [2:0] {IDLE, LOOKUP, BOUND, READ, OUTPUT, HALT} alu_state_e;

endpackage
